//--- ex_settings.svh
// Execute stage build constants
// Data width, register index width and the length of the divider loop
// shared by the package and the multi-cycle units

`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Integer data path width in bits
`define EX_XLEN 32

// Destination register index width
`define EX_REG_ADDR_W 5

// Restoring divider steps, one quotient bit per cycle
`define EX_DIV_CYCLES 32

`endif

//--- ex_pkg.sv
// Execute stage package
// Word and register index types plus the ALU, multiply and divide
// operator encodings used across the stage

`include "ex_settings.svh"

package ex_pkg;

  // Data word and register file index
  typedef logic [`EX_XLEN-1:0]       word_t;
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

  // Single-cycle ALU operators
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb
  } alu_op_e;

  // RV32M multiply, low word or one of three high word flavours
  typedef enum logic [1:0] {
    MUL_L   = 2'h0,
    MUL_H   = 2'h1,
    MUL_HSU = 2'h2,
    MUL_HU  = 2'h3
  } mul_op_e;

  // RV32M divide and remainder
  typedef enum logic [1:0] {
    DIV_S = 2'h0,
    DIV_U = 2'h1,
    REM_S = 2'h2,
    REM_U = 2'h3
  } div_op_e;

endpackage

//--- ex_muldiv_if.sv
// Multi-cycle unit handshake
// Connects the stage controller to one multiply or divide unit
// Controller starts, kills and acknowledges, the unit returns a held result

`timescale 1ns/1ps

interface ex_muldiv_if ();

  // Controller side
  logic          start;
  logic          kill;
  logic          ack;

  // Unit side, result stable while valid is high
  logic          valid;
  ex_pkg::word_t result;

  modport ctrl (
    output start, kill, ack,
    input  valid, result
  );

  modport unit (
    input  start, kill, ack,
    output valid, result
  );

endinterface

//--- ex_alu.sv
// Integer ALU
// Single-cycle add, subtract, logic, shift and set/compare operations
// Compare outcome doubles as the branch decision

`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_result_o
);

  import ex_pkg::*;

  // Shift amount from the low bits of operand b
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;

  assign shamt       = operand_b_i[4:0];
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;
  assign equal       = operand_a_i == operand_b_i;

  // Compare result, low for everything that is not a set/compare
  always_comb begin
    case (operator_i)
      ALU_SLT:  cmp_result_o = lt_signed;
      ALU_SLTU: cmp_result_o = lt_unsigned;
      ALU_EQ:   cmp_result_o = equal;
      ALU_NE:   cmp_result_o = !equal;
      default:  cmp_result_o = 1'b0;
    endcase
  end

  always_comb begin
    case (operator_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i;
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA: result_o = word_t'($signed(operand_a_i) >>> shamt);
      // Set and compare ops land in bit 0
      ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE: result_o = word_t'(cmp_result_o);
      default: result_o = '0;
    endcase
  end

endmodule

//--- ex_mult.sv
// Multiplier
// Forms the signed or unsigned 64-bit product of the RV32M multiply ops
// Result is registered on start and held until acknowledged or killed

`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_mult (
  input  logic            clk,
  input  logic            rst_n,
  input  ex_pkg::mul_op_e operator_i,
  input  ex_pkg::word_t   op_a_i,
  input  ex_pkg::word_t   op_b_i,
  ex_muldiv_if.unit       bus
);

  import ex_pkg::*;

  logic                          sign_a;
  logic                          sign_b;
  logic signed [`EX_XLEN:0]      a_ext;
  logic signed [`EX_XLEN:0]      b_ext;
  logic signed [2*`EX_XLEN+1:0]  product;
  word_t                         result_d;
  word_t                         result_q;
  logic                          valid_q;
  logic                          start_mul;

  // Operand a is signed for MULH and MULHSU, operand b only for MULH
  assign sign_a = (operator_i == MUL_H) || (operator_i == MUL_HSU);
  assign sign_b = (operator_i == MUL_H);

  // One extra bit turns every flavour into a signed multiply
  assign a_ext   = $signed({sign_a & op_a_i[`EX_XLEN-1], op_a_i});
  assign b_ext   = $signed({sign_b & op_b_i[`EX_XLEN-1], op_b_i});
  assign product = a_ext * b_ext;

  assign result_d = (operator_i == MUL_L) ? product[`EX_XLEN-1:0]
                                          : product[2*`EX_XLEN-1:`EX_XLEN];

  // A held result blocks a new start
  assign start_mul = bus.start && !valid_q && !bus.kill;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (bus.kill || bus.ack) begin
      valid_q <= 1'b0;
    end else if (start_mul) begin
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (start_mul) begin
      result_q <= result_d;
    end
  end

  assign bus.valid  = valid_q;
  assign bus.result = result_q;

endmodule

//--- ex_div.sv
// Iterative divider
// Restoring shift-subtract loop on operand magnitudes, one bit per cycle
// Sign correction afterwards, divide by zero and overflow follow RV32M

`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_div (
  input  logic            clk,
  input  logic            rst_n,
  input  ex_pkg::div_op_e operator_i,
  input  ex_pkg::word_t   op_a_i,
  input  ex_pkg::word_t   op_b_i,
  ex_muldiv_if.unit       bus
);

  import ex_pkg::*;

  localparam int unsigned cnt_w = $clog2(`EX_DIV_CYCLES);

  logic                 is_signed;
  logic                 a_neg;
  logic                 b_neg;
  word_t                mag_a;
  word_t                mag_b;
  logic                 start_div;
  logic                 busy_q;
  logic                 valid_q;
  logic [cnt_w-1:0]     cnt_q;
  // Loop state, quotient shares its register with the dividend
  word_t                quo_q;
  word_t                rem_q;
  word_t                dvs_q;
  logic                 neg_quo_q;
  logic                 neg_rem_q;
  logic                 is_rem_q;
  logic [`EX_XLEN:0]    shl;
  word_t                diff;
  logic                 fits;

  assign is_signed = (operator_i == DIV_S) || (operator_i == REM_S);
  assign a_neg     = is_signed && op_a_i[`EX_XLEN-1];
  assign b_neg     = is_signed && op_b_i[`EX_XLEN-1];
  assign mag_a     = a_neg ? -op_a_i : op_a_i;
  assign mag_b     = b_neg ? -op_b_i : op_b_i;

  assign start_div = bus.start && !busy_q && !valid_q && !bus.kill;

  // Next dividend bit enters the partial remainder
  assign shl  = {rem_q, quo_q[`EX_XLEN-1]};
  assign fits = shl >= {1'b0, dvs_q};
  // Low word is exact whenever the subtraction is kept
  assign diff = shl[`EX_XLEN-1:0] - dvs_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else if (bus.kill) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == cnt_w'(`EX_DIV_CYCLES - 1)) begin
        busy_q  <= 1'b0;
        valid_q <= 1'b1;
      end
    end else if (valid_q) begin
      if (bus.ack) begin
        valid_q <= 1'b0;
      end
    end else if (start_div) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_div) begin
      quo_q     <= mag_a;
      rem_q     <= '0;
      dvs_q     <= mag_b;
      // Divide by zero keeps the all-ones quotient unsigned
      neg_quo_q <= (a_neg ^ b_neg) && (op_b_i != '0);
      // Remainder takes the sign of the dividend
      neg_rem_q <= a_neg;
      is_rem_q  <= (operator_i == REM_S) || (operator_i == REM_U);
    end else if (busy_q) begin
      quo_q <= {quo_q[`EX_XLEN-2:0], fits};
      rem_q <= fits ? diff : shl[`EX_XLEN-1:0];
    end
  end

  // Most negative by minus one wraps back onto the dividend here
  assign bus.result = is_rem_q ? (neg_rem_q ? -rem_q : rem_q)
                               : (neg_quo_q ? -quo_q : quo_q);
  assign bus.valid  = valid_q;

endmodule

//--- ex_wb_pipe.sv
// Execute stage controller and EX/WB pipeline register
// Starts, kills and acknowledges the multi-cycle units, forms stage ready,
// selects the write data and advances the WB entry under wb_ready_i

`timescale 1ns/1ps

module ex_wb_pipe (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid_i,
  input  logic              kill_i,
  input  logic              alu_en_i,
  input  logic              mul_en_i,
  input  logic              div_en_i,
  input  logic              rf_we_i,
  input  ex_pkg::reg_addr_t rf_waddr_i,
  input  ex_pkg::word_t     alu_result_i,
  ex_muldiv_if.ctrl         mul_bus,
  ex_muldiv_if.ctrl         div_bus,
  input  logic              wb_ready_i,
  output logic              ex_ready_o,
  output logic              wb_valid_o,
  output logic              wb_rf_we_o,
  output ex_pkg::reg_addr_t wb_rf_waddr_o,
  output ex_pkg::word_t     wb_rf_wdata_o
);

  import ex_pkg::*;

  logic      unit_valid;
  logic      ex_valid;
  logic      capture;
  word_t     wdata_sel;
  logic      wb_valid_q;
  logic      wb_rf_we_q;
  reg_addr_t wb_rf_waddr_q;
  word_t     wb_rf_wdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Unit control
  ////////////////////////////////////////////////////////////////////////////

  // Start held for the whole life of an unkilled instruction in EX
  assign mul_bus.start = instr_valid_i && mul_en_i && !kill_i;
  assign div_bus.start = instr_valid_i && div_en_i && !kill_i;
  assign mul_bus.kill  = kill_i;
  assign div_bus.kill  = kill_i;

  // ALU is always done, multi-cycle units once their result shows up
  assign unit_valid = alu_en_i
                   || (mul_en_i && mul_bus.valid)
                   || (div_en_i && div_bus.valid);
  assign ex_valid   = instr_valid_i && !kill_i && unit_valid;
  assign capture    = ex_valid && wb_ready_i;

  assign mul_bus.ack = capture && mul_en_i;
  assign div_bus.ack = capture && div_en_i;

  // Killed instruction leaves at once, otherwise wait for WB
  assign ex_ready_o = kill_i || (wb_ready_i && (!instr_valid_i || unit_valid));

  ////////////////////////////////////////////////////////////////////////////
  // Result select and EX/WB register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (1'b1)
      mul_en_i: wdata_sel = mul_bus.result;
      div_en_i: wdata_sel = div_bus.result;
      default:  wdata_sel = alu_result_i;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_q <= 1'b0;
      wb_rf_we_q <= 1'b0;
    end else if (capture) begin
      wb_valid_q <= 1'b1;
      wb_rf_we_q <= rf_we_i;
    end else if (wb_ready_i) begin
      // Nothing ready, push a bubble
      wb_valid_q <= 1'b0;
      wb_rf_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      wb_rf_waddr_q <= rf_waddr_i;
      wb_rf_wdata_q <= wdata_sel;
    end
  end

  assign wb_valid_o    = wb_valid_q;
  assign wb_rf_we_o    = wb_rf_we_q;
  assign wb_rf_waddr_o = wb_rf_waddr_q;
  assign wb_rf_wdata_o = wb_rf_wdata_q;

endmodule

//--- ex_stage.sv
// Execute stage top level
// ALU, multiplier and divider behind one controller with an EX/WB register
// Valid/ready toward write-back and a kill input from the pipeline control

`timescale 1ns/1ps

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid_i,
  input  logic              kill_i,
  // One-hot unit select while valid
  input  logic              alu_en_i,
  input  logic              mul_en_i,
  input  logic              div_en_i,
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::mul_op_e   mul_operator_i,
  input  ex_pkg::div_op_e   div_operator_i,
  input  ex_pkg::word_t     operand_a_i,
  input  ex_pkg::word_t     operand_b_i,
  input  logic              rf_we_i,
  input  ex_pkg::reg_addr_t rf_waddr_i,
  input  logic              wb_ready_i,
  output logic              ex_ready_o,
  output logic              branch_decision_o,
  output logic              wb_valid_o,
  output logic              wb_rf_we_o,
  output ex_pkg::reg_addr_t wb_rf_waddr_o,
  output ex_pkg::word_t     wb_rf_wdata_o
);

  import ex_pkg::*;

  word_t alu_result;

  // One handshake bundle per multi-cycle unit
  ex_muldiv_if mul_bus ();
  ex_muldiv_if div_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////////////////////

  ex_alu i_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  ex_mult i_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (mul_operator_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .bus        (mul_bus.unit)
  );

  ex_div i_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (div_operator_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .bus        (div_bus.unit)
  );

  // Stage control and EX/WB register
  ex_wb_pipe i_wb_pipe (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .kill_i        (kill_i),
    .alu_en_i      (alu_en_i),
    .mul_en_i      (mul_en_i),
    .div_en_i      (div_en_i),
    .rf_we_i       (rf_we_i),
    .rf_waddr_i    (rf_waddr_i),
    .alu_result_i  (alu_result),
    .mul_bus       (mul_bus.ctrl),
    .div_bus       (div_bus.ctrl),
    .wb_ready_i    (wb_ready_i),
    .ex_ready_o    (ex_ready_o),
    .wb_valid_o    (wb_valid_o),
    .wb_rf_we_o    (wb_rf_we_o),
    .wb_rf_waddr_o (wb_rf_waddr_o),
    .wb_rf_wdata_o (wb_rf_wdata_o)
  );

endmodule

//--- tb_ex_stage.sv
// Execute stage testbench
// Random ALU, multiply and divide traffic with write-back back-pressure,
// forced divider corner cases and occasional kills of the instruction in EX
// Reference model feeds an in-order scoreboard on the EX/WB outputs

`timescale 1ns/1ps

module tb_ex_stage;

  import ex_pkg::*;

  localparam int unsigned num_instr  = 400;
  // Worst case is a divide stretched by back-pressure
  localparam int unsigned max_cycles = num_instr * 40;

  logic      clk;
  logic      rst_n;
  logic      instr_valid_i;
  logic      kill_i;
  logic      alu_en_i;
  logic      mul_en_i;
  logic      div_en_i;
  alu_op_e   alu_operator_i;
  mul_op_e   mul_operator_i;
  div_op_e   div_operator_i;
  word_t     operand_a_i;
  word_t     operand_b_i;
  logic      rf_we_i;
  reg_addr_t rf_waddr_i;
  logic      wb_ready_i;
  logic      ex_ready_o;
  logic      branch_decision_o;
  logic      wb_valid_o;
  logic      wb_rf_we_o;
  reg_addr_t wb_rf_waddr_o;
  word_t     wb_rf_wdata_o;

  logic [31:0] rng_state;
  int unsigned cycle_cnt = 0;
  // Index of the instruction at the stage inputs
  int unsigned cur_id;

  // Scoreboard, one entry per instruction that left EX unkilled
  logic        exp_we_q[$];
  reg_addr_t   exp_waddr_q[$];
  word_t       exp_wdata_q[$];
  int unsigned exp_id_q[$];

  ex_stage i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .instr_valid_i     (instr_valid_i),
    .kill_i            (kill_i),
    .alu_en_i          (alu_en_i),
    .mul_en_i          (mul_en_i),
    .div_en_i          (div_en_i),
    .alu_operator_i    (alu_operator_i),
    .mul_operator_i    (mul_operator_i),
    .div_operator_i    (div_operator_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .wb_ready_i        (wb_ready_i),
    .ex_ready_o        (ex_ready_o),
    .branch_decision_o (branch_decision_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o)
  );

  always #10 clk = !clk;

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_random(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  // Write-back accepts three cycles out of four
  task automatic drive_wb_ready();
    logic [31:0] r;
    draw_random(r);
    wb_ready_i <= (r[1:0] != 2'b00);
  endtask

  // Set/compare outcome, zero for arithmetic ops
  function automatic logic branch_model(alu_op_e op, word_t a, word_t b);
    int sa;
    int sb;
    sa = a;
    sb = b;
    case (op)
      ALU_SLT:  return sa < sb;
      ALU_SLTU: return a < b;
      ALU_EQ:   return a == b;
      ALU_NE:   return a != b;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
    int sa;
    sa = a;
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return word_t'(sa >>> b[4:0]);
      default: return {31'b0, branch_model(op, a, b)};
    endcase
  endfunction

  // Full 64-bit products, high or low word picked per operator
  function automatic word_t mul_model(mul_op_e op, word_t a, word_t b);
    longint      ss;
    longint      su;
    logic [63:0] uu;
    ss = longint'(int'(a)) * longint'(int'(b));
    su = longint'(int'(a)) * longint'({32'b0, b});
    uu = {32'b0, a} * {32'b0, b};
    case (op)
      MUL_L:   return ss[31:0];
      MUL_H:   return ss[63:32];
      MUL_HSU: return su[63:32];
      default: return uu[63:32];
    endcase
  endfunction

  function automatic word_t div_model(div_op_e op, word_t a, word_t b);
    int sa;
    int sb;
    sa = a;
    sb = b;
    // Divide by zero, all ones quotient and dividend as remainder
    if (b == '0) return (op == DIV_S || op == DIV_U) ? '1 : a;
    // Signed overflow
    if ((op == DIV_S || op == REM_S) && a == 32'h8000_0000 && b == '1) begin
      return (op == DIV_S) ? a : '0;
    end
    case (op)
      DIV_S:   return word_t'(sa / sb);
      DIV_U:   return a / b;
      REM_S:   return word_t'(sa % sb);
      default: return a % b;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_wdata(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1, "Write data mismatch");
    end
  endtask

  task automatic check_waddr(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (exp !== act) begin
      $display("** Error: %s expected %0d actual %0d", name, exp, act);
      $display("Test failed");
      $fatal(1, "Write address mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("** Error: %s expected %b actual %b", name, exp, act);
      $display("Test failed");
      $fatal(1, "Flag mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : scoreboard
    word_t       exp_wdata;
    int unsigned id;
    if (rst_n) begin
      // Branch decision is combinational on the current inputs
      if (instr_valid_i && alu_en_i && !kill_i) begin
        check_flag($sformatf("instr %0d branch", cur_id),
                   branch_model(alu_operator_i, operand_a_i, operand_b_i),
                   branch_decision_o);
      end
      // WB takes its entry at this edge
      if (wb_valid_o && wb_ready_i) begin
        if (exp_id_q.size() == 0) begin
          $display("WB accepted an entry with no issued instruction behind it");
          $display("Test failed");
          $fatal(1, "Unexpected write-back entry");
        end else begin
          id = exp_id_q.pop_front();
          check_flag($sformatf("instr %0d rf_we", id), exp_we_q.pop_front(), wb_rf_we_o);
          check_waddr($sformatf("instr %0d waddr", id), exp_waddr_q.pop_front(),
                      wb_rf_waddr_o);
          check_wdata($sformatf("instr %0d wdata", id), exp_wdata_q.pop_front(),
                      wb_rf_wdata_o);
        end
      end
      // Instruction leaving EX unkilled
      if (instr_valid_i && ex_ready_o && !kill_i) begin
        if (alu_en_i) begin
          exp_wdata = alu_model(alu_operator_i, operand_a_i, operand_b_i);
        end else if (mul_en_i) begin
          exp_wdata = mul_model(mul_operator_i, operand_a_i, operand_b_i);
        end else begin
          exp_wdata = div_model(div_operator_i, operand_a_i, operand_b_i);
        end
        exp_id_q.push_back(cur_id);
        exp_we_q.push_back(rf_we_i);
        exp_waddr_q.push_back(rf_waddr_i);
        exp_wdata_q.push_back(exp_wdata);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout, run did not finish within %0d cycles", max_cycles);
      $display("Test failed");
      $fatal(1, "Simulation timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [1:0]  unit;
    word_t       a;
    word_t       b;
    logic        kill_this;
    int unsigned kill_delay;
    int unsigned wait_cnt;
    logic        accepted;
    clk            = 1'b0;
    rst_n          = 1'b0;
    instr_valid_i  = 1'b0;
    kill_i         = 1'b0;
    alu_en_i       = 1'b0;
    mul_en_i       = 1'b0;
    div_en_i       = 1'b0;
    alu_operator_i = ALU_ADD;
    mul_operator_i = MUL_L;
    div_operator_i = DIV_S;
    operand_a_i    = '0;
    operand_b_i    = '0;
    rf_we_i        = 1'b0;
    rf_waddr_i     = '0;
    wb_ready_i     = 1'b0;
    cur_id         = 0;
    rng_state      = 32'd55211;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_flag("reset wb_valid", 1'b0, wb_valid_o);

    for (int n = 0; n < num_instr; n++) begin
      draw_random(r);
      // Occasional empty cycle between instructions
      if (r[2:0] == 3'd0) begin
        instr_valid_i <= 1'b0;
        alu_en_i      <= 1'b0;
        mul_en_i      <= 1'b0;
        div_en_i      <= 1'b0;
        kill_i        <= 1'b0;
        drive_wb_ready();
        @(posedge clk);
      end
      // Unit mix: half ALU, a quarter each multiply and divide
      draw_random(r);
      unit = r[1:0];
      alu_en_i       <= (unit < 2'd2);
      mul_en_i       <= (unit == 2'd2);
      div_en_i       <= (unit == 2'd3);
      alu_operator_i <= alu_op_e'(4'(r[15:8] % 12));
      mul_operator_i <= mul_op_e'(r[17:16]);
      div_operator_i <= div_op_e'(r[19:18]);
      rf_we_i        <= r[20];
      rf_waddr_i     <= r[25:21];
      kill_this = (r[31:29] == 3'b111);
      draw_random(r);
      a = r;
      draw_random(r);
      b = r;
      draw_random(r);
      // Equal operands so EQ and NE both show up
      if (r[2:0] == 3'd0) b = a;
      // Divider corner cases
      if (unit == 2'd3 && r[5:3] == 3'd0) b = '0;
      if (unit == 2'd3 && r[5:3] == 3'd1) begin
        a = 32'h8000_0000;
        b = '1;
      end
      kill_delay = r[12:8] % 24;
      operand_a_i   <= a;
      operand_b_i   <= b;
      instr_valid_i <= 1'b1;
      kill_i        <= kill_this && (kill_delay == 0);
      cur_id        <= n;
      drive_wb_ready();

      // Hold until EX lets go, kill may land mid-flight
      wait_cnt = 0;
      accepted = 1'b0;
      while (!accepted) begin
        @(posedge clk);
        accepted = ex_ready_o;
        wait_cnt++;
        if (!accepted) begin
          drive_wb_ready();
          if (kill_this && wait_cnt >= kill_delay) kill_i <= 1'b1;
        end
      end
    end

    // Drain the EX/WB register with write-back ready
    instr_valid_i <= 1'b0;
    alu_en_i      <= 1'b0;
    mul_en_i      <= 1'b0;
    div_en_i      <= 1'b0;
    kill_i        <= 1'b0;
    wb_ready_i    <= 1'b1;
    while (exp_id_q.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
    check_flag("drain wb_valid", 1'b0, wb_valid_o);
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
ex_pkg.sv
ex_muldiv_if.sv
ex_alu.sv
ex_mult.sv
ex_div.sv
ex_wb_pipe.sv
ex_stage.sv
tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

export_include_dirs:
  - .

sources:
  - ex_pkg.sv
  - ex_muldiv_if.sv
  - ex_alu.sv
  - ex_mult.sv
  - ex_div.sv
  - ex_wb_pipe.sv
  - ex_stage.sv
  - target: simulation
    files:
      - tb_ex_stage.sv
